// ==== logic/dino_pkg.sv ====
// Fixed 1280x480 timing at a 50 MHz pixel clock; all objects are 32 rows tall
package dino_pkg;

    localparam int H_ACTIVE = 1280;
    localparam int H_FRONT  = 32;
    localparam int H_SYNC   = 192;
    localparam int H_BACK   = 96;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 1600

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 525

    localparam int HCOUNT_W = 11;
    localparam int VCOUNT_W = 10;
    localparam int COORD_W  = 11;
    localparam int EXT_W    = COORD_W + 1;  // Room for x plus width

    // Cactus, group, lava, pterodactyl
    localparam int OBST_COUNT = 4;
    localparam int OBST_START_X [OBST_COUNT] = '{1200, 1600, 1800, 1400};
    localparam int OBST_Y [OBST_COUNT] = '{248, 248, 248, 200};
    localparam int OBST_W [OBST_COUNT] = '{32, 64, 32, 32};
    localparam int OBST_H = 32;

    localparam int DINO_SIZE    = 32;
    localparam int DINO_START_X = 100;
    localparam int DINO_START_Y = 248;

    localparam int LFSR_W = 6;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 6'b101011;
    localparam int SPEED_W    = 11;
    localparam int PASS_LIMIT = 12;
    localparam int PASS_W     = $clog2(PASS_LIMIT);
    localparam int MOTION_TICKS = 2_000_000;

    localparam int N_DIGITS = 5;
    localparam int SCORE_X  = 120;
    localparam int SCORE_Y  = 10;
    localparam int GLYPH    = 8;

    localparam int BANNER_X = 560;
    localparam int BANNER_Y = 200;
    localparam int BANNER_W = 160;
    localparam int BANNER_H = 32;

    localparam int GROUND_LINE = 280;
    localparam int GROUND_DEEP = 300;

    localparam logic [8:0] REG_DINO_X = 9'd0;
    localparam logic [8:0] REG_DINO_Y = 9'd1;
    localparam logic [8:0] REG_REPLAY = 9'd19;

    localparam logic [23:0] SKY        = 24'h87CEEB;
    localparam logic [23:0] GROUND_TOP = 24'h8B4513;
    localparam logic [23:0] GROUND_LOW = 24'h64280A;
    localparam logic [23:0] LINE       = 24'h000000;
    localparam logic [23:0] DINO       = 24'h535353;
    localparam logic [23:0] CACTUS     = 24'h008000;
    localparam logic [23:0] GROUP      = 24'h005000;
    localparam logic [23:0] LAVA       = 24'hFF4500;
    localparam logic [23:0] PTERO      = 24'h808080;
    localparam logic [23:0] DIGIT      = 24'h000000;
    localparam logic [23:0] BANNER     = 24'hFFFF00;
    localparam logic [23:0] OBST_COLOR [OBST_COUNT] = '{CACTUS, GROUP, LAVA, PTERO};

    typedef enum logic {
        PHASE_RUN,
        PHASE_OVER
    } phase_t;

    // Row 0 is the top of the glyph, bit 7 the leftmost pixel
    function automatic logic [7:0] digit_row(input logic [3:0] digit, input logic [2:0] row);
        logic [63:0] glyph;
        case (digit)
            4'd0: glyph = 64'h3C66_6E7E_7666_3C00;
            4'd1: glyph = 64'h1838_1818_1818_7E00;
            4'd2: glyph = 64'h3C66_061C_3066_7E00;
            4'd3: glyph = 64'h3C66_061C_0666_3C00;
            4'd4: glyph = 64'h0C1C_2C4C_7E0C_0C00;
            4'd5: glyph = 64'h7E60_7C06_0666_3C00;
            4'd6: glyph = 64'h3C66_607C_6666_3C00;
            4'd7: glyph = 64'h7E06_0C18_3030_3000;
            4'd8: glyph = 64'h3C66_663C_6666_3C00;
            4'd9: glyph = 64'h3C66_663E_0666_3C00;
            default: glyph = '0;
        endcase
        return glyph[8 * (7 - row) +: 8];
    endfunction

endpackage

// ==== logic/vga_timing.sv ====
// Counters start at zero out of reset; sync pulses are active low, sync_n tied low
module vga_timing import dino_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    output logic [HCOUNT_W-1:0] hcount,
    output logic [VCOUNT_W-1:0] vcount,
    output logic                vga_clk,
    output logic                vga_hs,
    output logic                vga_vs,
    output logic                vga_blank_n,
    output logic                vga_sync_n
);

    logic end_of_line;
    logic end_of_field;

    assign end_of_line  = (hcount == HCOUNT_W'(H_TOTAL - 1));
    assign end_of_field = (vcount == VCOUNT_W'(V_TOTAL - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
            vcount <= end_of_field ? '0 : vcount + VCOUNT_W'(1);
        end else begin
            hcount <= hcount + HCOUNT_W'(1);
        end
    end

    assign vga_hs = !((hcount >= HCOUNT_W'(H_ACTIVE + H_FRONT)) &&
                      (hcount < HCOUNT_W'(H_ACTIVE + H_FRONT + H_SYNC)));
    assign vga_vs = !((vcount >= VCOUNT_W'(V_ACTIVE + V_FRONT)) &&
                      (vcount < VCOUNT_W'(V_ACTIVE + V_FRONT + V_SYNC)));
    assign vga_blank_n = (hcount < HCOUNT_W'(H_ACTIVE)) && (vcount < VCOUNT_W'(V_ACTIVE));
    assign vga_sync_n  = 1'b0;
    assign vga_clk     = hcount[0];    // Half rate DAC clock

endmodule

// ==== logic/obstacle_field.sv ====
// Moves only on tick; respawn x stays below 2048 so x plus width fits 12 bits
module obstacle_field import dino_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               tick,
    input  logic               restart,
    output logic [COORD_W-1:0] obst_x [OBST_COUNT]
);

    logic [LFSR_W-1:0]  lfsr;
    logic [SPEED_W-1:0] speed;
    logic [PASS_W-1:0]  pass_count;
    logic [COORD_W-1:0] offset [OBST_COUNT];
    logic [OBST_COUNT-1:0] respawn;

    // x^6 + x^5 + 1 feedback that restart leaves running
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else if (tick) begin
            lfsr <= {lfsr[LFSR_W-2:0], lfsr[LFSR_W-1] ^ lfsr[LFSR_W-2]};
        end
    end

    // A different slice of the LFSR per obstacle
    always_comb begin
        offset[0] = {2'b00, lfsr, 3'b000};
        offset[1] = {2'b00, ~lfsr, 3'b000};
        offset[2] = {2'b00, lfsr[3:0], 5'b00000};
        offset[3] = {2'b00, lfsr[5:2], 5'b00000};
        for (int i = 0; i < OBST_COUNT; i++) begin
            respawn[i] = (obst_x[i] <= speed);  // Would pass the left edge
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < OBST_COUNT; i++) begin
                obst_x[i] <= COORD_W'(OBST_START_X[i]);
            end
        end else if (restart) begin
            for (int i = 0; i < OBST_COUNT; i++) begin
                obst_x[i] <= COORD_W'(OBST_START_X[i]);
            end
        end else if (tick) begin
            for (int i = 0; i < OBST_COUNT; i++) begin
                if (respawn[i]) begin
                    obst_x[i] <= COORD_W'(H_ACTIVE) + offset[i];
                end else begin
                    obst_x[i] <= obst_x[i] - speed;
                end
            end
        end
    end

    // Speed-up after PASS_LIMIT ticks with a respawn
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            speed      <= SPEED_W'(1);
            pass_count <= '0;
        end else if (restart) begin
            speed      <= SPEED_W'(1);
            pass_count <= '0;
        end else if (tick && |respawn) begin
            if (pass_count == PASS_W'(PASS_LIMIT - 1)) begin
                speed      <= speed + SPEED_W'(1);
                pass_count <= '0;
            end else begin
                pass_count <= pass_count + PASS_W'(1);
            end
        end
    end

endmodule

// ==== logic/bcd_score.sv ====
// Decimal score that adds one per tick and wraps 99999 to 00000; digit 0 is the units
module bcd_score import dino_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       tick,
    input  logic       restart,
    output logic [3:0] digits [N_DIGITS]
);

    logic [3:0] next_digits [N_DIGITS];
    logic       carry;

    // Ripple the increment up from the units digit
    always_comb begin
        carry = 1'b1;
        for (int i = 0; i < N_DIGITS; i++) begin
            if (carry && digits[i] == 4'd9) begin
                next_digits[i] = 4'd0;
            end else if (carry) begin
                next_digits[i] = digits[i] + 4'd1;
                carry          = 1'b0;
            end else begin
                next_digits[i] = digits[i];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            digits <= '{default: 4'd0};
        end else if (restart) begin
            digits <= '{default: 4'd0};
        end else if (tick) begin
            digits <= next_digits;
        end
    end

endmodule

// ==== logic/game_control.sv ====
// Writes land in the same cycle as motion; only addresses 0, 1 and 19 are decoded
module game_control import dino_pkg::*; #(
    parameter int motion_ticks = MOTION_TICKS
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               chipselect,
    input  logic               write,
    input  logic [8:0]         address,
    input  logic [31:0]        writedata,
    output logic [COORD_W-1:0] dino_x,
    output logic [COORD_W-1:0] dino_y,
    output logic [COORD_W-1:0] obst_x [OBST_COUNT],
    output logic [3:0]         digits [N_DIGITS],
    output phase_t             phase
);

    localparam int TIMER_W = (motion_ticks > 1) ? $clog2(motion_ticks) : 1;

    logic               replay;
    logic [TIMER_W-1:0] timer;
    logic               tick;
    logic               restart;
    logic               hit;

    function automatic logic overlap(input logic [EXT_W-1:0] ax, ay, bx, by, bw);
        return (ax < bx + bw) && (ax + EXT_W'(DINO_SIZE) > bx) &&
               (ay < by + EXT_W'(OBST_H)) && (ay + EXT_W'(DINO_SIZE) > by);
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dino_x <= COORD_W'(DINO_START_X);
            dino_y <= COORD_W'(DINO_START_Y);
            replay <= 1'b0;
        end else if (chipselect && write) begin
            case (address)
                REG_DINO_X: dino_x <= writedata[COORD_W-1:0];
                REG_DINO_Y: dino_y <= writedata[COORD_W-1:0];
                REG_REPLAY: replay <= writedata[0];   // Level held until rewritten
                default: ;
            endcase
        end
    end

    assign tick    = (phase == PHASE_RUN) && (timer == TIMER_W'(motion_ticks - 1));
    assign restart = (phase == PHASE_OVER) && replay;

    // Timer only runs during play
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            timer <= '0;
        end else if (restart || tick) begin
            timer <= '0;
        end else if (phase == PHASE_RUN) begin
            timer <= timer + TIMER_W'(1);
        end
    end

    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < OBST_COUNT; i++) begin
            if (overlap(EXT_W'(dino_x), EXT_W'(dino_y), EXT_W'(obst_x[i]),
                        EXT_W'(OBST_Y[i]), EXT_W'(OBST_W[i]))) begin
                hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= PHASE_RUN;
        end else if (restart) begin
            phase <= PHASE_RUN;
        end else if (phase == PHASE_RUN && hit) begin
            phase <= PHASE_OVER;
        end
    end

    obstacle_field obstacle_field_inst (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick),
        .restart (restart),
        .obst_x  (obst_x)
    );

    bcd_score bcd_score_inst (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick),
        .restart (restart),
        .digits  (digits)
    );

endmodule

// ==== logic/pixel_renderer.sv ====
// Colour lags the counters by one clock; blanking is left to vga_blank_n
module pixel_renderer import dino_pkg::*; (
    input  logic                clk,
    input  logic [HCOUNT_W-1:0] hcount,
    input  logic [VCOUNT_W-1:0] vcount,
    input  logic [COORD_W-1:0]  dino_x,
    input  logic [COORD_W-1:0]  dino_y,
    input  logic [COORD_W-1:0]  obst_x [OBST_COUNT],
    input  logic [3:0]          digits [N_DIGITS],
    input  phase_t              phase,
    output logic [7:0]          vga_r,
    output logic [7:0]          vga_g,
    output logic [7:0]          vga_b
);

    logic [EXT_W-1:0] px;
    logic [EXT_W-1:0] py;
    logic [EXT_W-1:0] score_dx;
    logic [EXT_W-1:0] score_dy;
    logic [2:0]       glyph_idx;
    logic [2:0]       glyph_col;
    logic [2:0]       glyph_row;
    logic [3:0]       glyph_digit;
    logic [7:0]       glyph_bits;
    logic             in_score;
    logic             in_banner;
    logic [23:0]      color;

    function automatic logic in_box(input logic [EXT_W-1:0] x, y, bx, by, bw, bh);
        return (x >= bx) && (x < bx + bw) && (y >= by) && (y < by + bh);
    endfunction

    assign px = EXT_W'(hcount);
    assign py = EXT_W'(vcount);

    // Score area split into 8x8 cells
    assign score_dx  = px - EXT_W'(SCORE_X);
    assign score_dy  = py - EXT_W'(SCORE_Y);
    assign glyph_idx = score_dx[5:3];
    assign glyph_col = score_dx[2:0];
    assign glyph_row = score_dy[2:0];
    assign in_score  = in_box(px, py, EXT_W'(SCORE_X), EXT_W'(SCORE_Y),
                              EXT_W'(N_DIGITS * GLYPH), EXT_W'(GLYPH));

    // Leftmost cell shows the highest digit
    assign glyph_digit = in_score ? digits[3'(N_DIGITS - 1) - glyph_idx] : 4'd0;
    assign glyph_bits  = digit_row(glyph_digit, glyph_row);

    assign in_banner = in_box(px, py, EXT_W'(BANNER_X), EXT_W'(BANNER_Y),
                              EXT_W'(BANNER_W), EXT_W'(BANNER_H));

    always_comb begin
        if (phase == PHASE_OVER) begin
            color = in_banner ? BANNER : SKY;
        end else begin
            if (py < EXT_W'(GROUND_LINE)) begin
                color = SKY;
            end else if (py == EXT_W'(GROUND_LINE)) begin
                color = LINE;
            end else if (py <= EXT_W'(GROUND_DEEP)) begin
                color = GROUND_TOP;
            end else begin
                color = GROUND_LOW;
            end

            if (in_box(px, py, EXT_W'(dino_x), EXT_W'(dino_y),
                       EXT_W'(DINO_SIZE), EXT_W'(DINO_SIZE))) begin
                color = DINO;
            end

            // Later obstacles win
            for (int i = 0; i < OBST_COUNT; i++) begin
                if (in_box(px, py, EXT_W'(obst_x[i]), EXT_W'(OBST_Y[i]),
                           EXT_W'(OBST_W[i]), EXT_W'(OBST_H))) begin
                    color = OBST_COLOR[i];
                end
            end

            if (in_score && glyph_bits[3'd7 - glyph_col]) begin
                color = DIGIT;
            end
        end
    end

    always_ff @(posedge clk) begin
        {vga_r, vga_g, vga_b} <= color;
    end

endmodule

// ==== logic/dino_top.sv ====
// motion_ticks sets clocks per game step; the bus has no wait states or read path
module dino_top import dino_pkg::*; #(
    parameter int motion_ticks = MOTION_TICKS
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        chipselect,
    input  logic        write,
    input  logic [8:0]  address,
    input  logic [31:0] writedata,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b,
    output logic        vga_clk,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_blank_n,
    output logic        vga_sync_n
);

    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic [COORD_W-1:0]  dino_x;
    logic [COORD_W-1:0]  dino_y;
    logic [COORD_W-1:0]  obst_x [OBST_COUNT];
    logic [3:0]          digits [N_DIGITS];
    phase_t              phase;

    vga_timing vga_timing_inst (
        .clk         (clk),
        .reset       (reset),
        .hcount      (hcount),
        .vcount      (vcount),
        .vga_clk     (vga_clk),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_sync_n  (vga_sync_n)
    );

    game_control #(.motion_ticks(motion_ticks)) game_control_inst (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .dino_x     (dino_x),
        .dino_y     (dino_y),
        .obst_x     (obst_x),
        .digits     (digits),
        .phase      (phase)
    );

    pixel_renderer pixel_renderer_inst (
        .clk    (clk),
        .hcount (hcount),
        .vcount (vcount),
        .dino_x (dino_x),
        .dino_y (dino_y),
        .obst_x (obst_x),
        .digits (digits),
        .phase  (phase),
        .vga_r  (vga_r),
        .vga_g  (vga_g),
        .vga_b  (vga_b)
    );

endmodule

// ==== tests/tb_clock.sv ====
// Free-running 40 ns clock; reset held high for four rising edges, released 2 ns after the last
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #2 reset = 1'b0;   // Same phase as the stimulus
    end

endmodule

// ==== tests/dino_tb.sv ====
// Tracks raster position by counting cycles from reset release; assumes no respawn before test 5
module dino_tb import dino_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MOTION    = 4000;
    localparam int FRAME     = H_TOTAL * V_TOTAL;
    localparam int RAND_SEED = 87993;

    logic        clk;
    logic        reset;
    logic        chipselect;
    logic        write;
    logic [8:0]  address;
    logic [31:0] writedata;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_clk;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    logic        vga_sync_n;

    longint cycles;
    longint run_base;      // Cycle where the score last started from zero
    int     mismatch_count;
    int     failure_count;

    tb_clock tb_clock_inst (
        .clk   (clk),
        .reset (reset)
    );

    dino_top #(.motion_ticks(MOTION)) dino_top_inst (
        .clk         (clk),
        .reset       (reset),
        .chipselect  (chipselect),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_clk     (vga_clk),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_sync_n  (vga_sync_n)
    );

    // Equals the raster position index while the counters run
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            mismatch_count++;
            $display("ERR %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    // 8x8 font with the top row first and the MSB leftmost
    function automatic logic [7:0] font_row(input int digit, input int row);
        logic [63:0] glyph;
        case (digit)
            0: glyph = {8'h3C, 8'h66, 8'h6E, 8'h7E, 8'h76, 8'h66, 8'h3C, 8'h00};
            1: glyph = {8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00};
            2: glyph = {8'h3C, 8'h66, 8'h06, 8'h1C, 8'h30, 8'h66, 8'h7E, 8'h00};
            3: glyph = {8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00};
            4: glyph = {8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C, 8'h00};
            5: glyph = {8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00};
            6: glyph = {8'h3C, 8'h66, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00};
            7: glyph = {8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00};
            8: glyph = {8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00};
            default: glyph = {8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h66, 8'h3C, 8'h00};
        endcase
        return glyph[63 - 8 * row -: 8];
    endfunction

    function automatic logic [23:0] ground_color(input int v);
        if (v < GROUND_LINE) begin
            return SKY;
        end else if (v == GROUND_LINE) begin
            return LINE;
        end else if (v <= GROUND_DEEP) begin
            return GROUND_TOP;
        end
        return GROUND_LOW;
    endfunction

    task automatic bus_write(input logic [8:0] addr, input logic [31:0] data);
        chipselect = 1'b1;
        write      = 1'b1;
        address    = addr;
        writedata  = data;
        @(posedge clk);
        #2;
        chipselect = 1'b0;
        write      = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Colour of (h, v) is on the outputs one clock after the counters hold it
    task automatic wait_pixel(input int h, input int v);
        int target;
        int n;
        bit found;
        target = (v * H_TOTAL + h + 1) % FRAME;
        found  = 1'b0;
        n      = 0;
        while (!found && n < FRAME + 2) begin
            @(posedge clk);
            #2;
            n++;
            found = ((cycles % FRAME) == target);
        end
        if (!found) begin
            failure_count++;
            $display("Timed out waiting for pixel (%0d, %0d)", h, v);
        end
    endtask

    task automatic sample_pixel(input int h, input int v, input logic [23:0] expected);
        wait_pixel(h, v);
        compare($sformatf("rgb(%0d,%0d)", h, v), {vga_r, vga_g, vga_b}, expected);
    endtask

    task automatic score_rows;
        int count;
        int digit;
        int place;
        logic [7:0] bits;
        for (int r = 0; r < GLYPH; r++) begin
            for (int c = 0; c < N_DIGITS * GLYPH; c++) begin
                wait_pixel(SCORE_X + c, SCORE_Y + r);
                count = int'((cycles - 1 - run_base) / MOTION);
                place = N_DIGITS - 1 - c / GLYPH;   // Leftmost cell is the top digit
                digit = count;
                for (int k = 0; k < place; k++) begin
                    digit = digit / 10;
                end
                digit = digit % 10;
                bits  = font_row(digit, r);
                compare($sformatf("score(%0d,%0d)", SCORE_X + c, SCORE_Y + r),
                        {vga_r, vga_g, vga_b}, bits[GLYPH - 1 - c % GLYPH] ? DIGIT : SKY);
            end
        end
    endtask

    task automatic verify_sync;
        int pos;
        int h;
        int v;
        int hs_low;
        int vs_low;
        logic exp_hs;
        logic exp_vs;
        logic exp_blank;
        hs_low = 0;
        vs_low = 0;
        for (int n = 0; n < FRAME; n++) begin
            @(posedge clk);
            #2;
            pos = int'(cycles % FRAME);
            h   = pos % H_TOTAL;
            v   = pos / H_TOTAL;
            exp_hs    = !(h >= H_ACTIVE + H_FRONT && h < H_ACTIVE + H_FRONT + H_SYNC);
            exp_vs    = !(v >= V_ACTIVE + V_FRONT && v < V_ACTIVE + V_FRONT + V_SYNC);
            exp_blank = (h < H_ACTIVE) && (v < V_ACTIVE);
            compare("vga_hs", vga_hs, exp_hs);
            compare("vga_vs", vga_vs, exp_vs);
            compare("vga_blank_n", vga_blank_n, exp_blank);
            compare("vga_sync_n", vga_sync_n, 1'b0);
            compare("vga_clk", vga_clk, h % 2);
            if (n < H_TOTAL && !vga_hs) begin
                hs_low++;
            end
            if (!vga_vs) begin
                vs_low++;
            end
        end
        compare("hs_low_clocks", hs_low, H_SYNC);
        compare("vs_low_lines", vs_low / H_TOTAL, V_SYNC);
        compare("vs_low_partial", vs_low % H_TOTAL, 0);
    endtask

    // Rows chosen clear of the dino, score and obstacle lanes
    task automatic background_rows;
        int rows [5];
        bus_write(REG_DINO_Y, 100);
        rows[0] = 140 + $urandom % 30;
        rows[1] = 170 + $urandom % 30;
        rows[2] = GROUND_LINE;
        rows[3] = GROUND_LINE + 1 + $urandom % (GROUND_DEEP - GROUND_LINE);
        rows[4] = GROUND_DEEP + 1 + $urandom % (V_ACTIVE - GROUND_DEEP - 1);
        foreach (rows[i]) begin
            sample_pixel($urandom % H_ACTIVE, rows[i], ground_color(rows[i]));
        end
    endtask

    task automatic dino_box;
        int x;
        int y;
        x = 1 + $urandom % 1240;
        y = 20 + $urandom % 140;
        bus_write(REG_DINO_X, x);
        bus_write(REG_DINO_Y, y);
        sample_pixel(x, y - 1, SKY);
        sample_pixel(x, y, DINO);
        sample_pixel(x - 1, y + 16, SKY);
        sample_pixel(x + 16, y + 16, DINO);
        sample_pixel(x + DINO_SIZE, y + 16, SKY);
        sample_pixel(x + DINO_SIZE - 1, y + DINO_SIZE - 1, DINO);
        sample_pixel(x, y + DINO_SIZE, SKY);
    endtask

    task automatic score_glyphs;
        bus_write(REG_DINO_X, 600);
        bus_write(REG_DINO_Y, 120);
        score_rows();
    endtask

    task automatic collision_replay;
        longint ticks;
        int cactus_x;
        int x;
        ticks = (cycles - run_base) / MOTION;
        cactus_x = OBST_START_X[0] - int'(ticks);   // Speed 1 until the first respawn
        bus_write(REG_DINO_X, cactus_x);
        bus_write(REG_DINO_Y, OBST_Y[0]);
        idle_cycles(2);
        sample_pixel(BANNER_X + $urandom % BANNER_W, BANNER_Y + $urandom % BANNER_H, BANNER);
        sample_pixel($urandom % H_ACTIVE, GROUND_DEEP + 50, SKY);

        bus_write(REG_DINO_Y, 100);
        wait_pixel(0, SCORE_Y - 2);
        bus_write(REG_REPLAY, 1);
        run_base = cycles + 1;    // Phase back to run one clock later
        bus_write(REG_REPLAY, 0);
        score_rows();
        x = $urandom % H_ACTIVE;
        sample_pixel(x, GROUND_LINE, LINE);
        sample_pixel(x, GROUND_LINE + 1 + $urandom % (GROUND_DEEP - GROUND_LINE), GROUND_TOP);
        sample_pixel(x, GROUND_DEEP + 1 + $urandom % 100, GROUND_LOW);
    endtask

    initial begin
        int seed_state;
        int n;
        chipselect     = 1'b0;
        write          = 1'b0;
        address        = '0;
        writedata      = '0;
        run_base       = 0;
        mismatch_count = 0;
        failure_count  = 0;
        seed_state     = $urandom(RAND_SEED);

        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
        end while (reset && n < 20);
        if (reset) begin
            failure_count++;
            $display("Reset was never released");
        end

        verify_sync();
        background_rows();
        dino_box();
        score_glyphs();
        collision_replay();

        $display("Summary: %0d value mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
logic/dino_pkg.sv
logic/vga_timing.sv
logic/obstacle_field.sv
logic/bcd_score.sv
logic/game_control.sv
logic/pixel_renderer.sv
logic/dino_top.sv
tests/tb_clock.sv
tests/dino_tb.sv

// ==== Bender.yml ====
package:
  name: dino_runner

sources:
  - logic/dino_pkg.sv
  - logic/vga_timing.sv
  - logic/obstacle_field.sv
  - logic/bcd_score.sv
  - logic/game_control.sv
  - logic/pixel_renderer.sv
  - logic/dino_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/dino_tb.sv
